// ==== riscv_id_pkg.sv ====
package riscv_id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALUOP_W    = 8;
    localparam int ALUSEL_W   = 3;

    // Major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA

    localparam logic [ALUOP_W-1:0] ALUOP_NOP  = 8'h00;
    localparam logic [ALUOP_W-1:0] ALUOP_OR   = 8'h25;
    localparam logic [ALUOP_W-1:0] ALUOP_AND  = 8'h24;
    localparam logic [ALUOP_W-1:0] ALUOP_XOR  = 8'h26;
    localparam logic [ALUOP_W-1:0] ALUOP_SLT  = 8'h2a;
    localparam logic [ALUOP_W-1:0] ALUOP_SLTU = 8'h2b;
    localparam logic [ALUOP_W-1:0] ALUOP_SLL  = 8'h7c;
    localparam logic [ALUOP_W-1:0] ALUOP_SRL  = 8'h02;
    localparam logic [ALUOP_W-1:0] ALUOP_SRA  = 8'h03;
    localparam logic [ALUOP_W-1:0] ALUOP_ADD  = 8'h20;
    localparam logic [ALUOP_W-1:0] ALUOP_SUB  = 8'h22;
    localparam logic [ALUOP_W-1:0] ALUOP_LUI  = 8'h5c;
    localparam logic [ALUOP_W-1:0] ALUOP_JAL  = 8'h50;
    localparam logic [ALUOP_W-1:0] ALUOP_JALR = 8'h09;
    localparam logic [ALUOP_W-1:0] ALUOP_BEQ  = 8'h51;
    localparam logic [ALUOP_W-1:0] ALUOP_BNE  = 8'h52;
    localparam logic [ALUOP_W-1:0] ALUOP_BLT  = 8'h53;
    localparam logic [ALUOP_W-1:0] ALUOP_BGE  = 8'h54;
    localparam logic [ALUOP_W-1:0] ALUOP_BLTU = 8'h55;
    localparam logic [ALUOP_W-1:0] ALUOP_BGEU = 8'h56;

    localparam logic [ALUSEL_W-1:0] SEL_NOP         = 3'b000;
    localparam logic [ALUSEL_W-1:0] SEL_LOGIC       = 3'b001;
    localparam logic [ALUSEL_W-1:0] SEL_SHIFT       = 3'b010;
    localparam logic [ALUSEL_W-1:0] SEL_ARITH       = 3'b100;
    localparam logic [ALUSEL_W-1:0] SEL_JUMP_BRANCH = 3'b110;

    // Same instruction word, R-type and I-type field layouts
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
    } inst_u;

endpackage

// ==== inst_decoder.sv ====
`timescale 1ns/1ns

module inst_decoder (
    input  riscv_id_pkg::inst_u                       inst_i,
    output logic [riscv_id_pkg::ALUOP_W-1:0]          aluop_o,
    output logic [riscv_id_pkg::ALUSEL_W-1:0]         alusel_o,
    output logic [riscv_id_pkg::REG_ADDR_W-1:0]       wd_o,
    output logic                                      wreg_o,
    output logic                                      reg1_read_o,
    output logic                                      reg2_read_o,
    output logic [riscv_id_pkg::REG_ADDR_W-1:0]       reg1_addr_o,
    output logic [riscv_id_pkg::REG_ADDR_W-1:0]       reg2_addr_o
);
    import riscv_id_pkg::*;

    logic f7_ok;

    // Only SUB and SRA may carry the alternate funct7
    assign f7_ok = (inst_i.r.funct7 == F7_BASE) ||
                   ((inst_i.r.funct7 == F7_ALT) &&
                    ((inst_i.r.funct3 == F3_ADD_SUB) || (inst_i.r.funct3 == F3_SRL_SRA)));

    always_comb begin
        aluop_o     = ALUOP_NOP;
        alusel_o    = SEL_NOP;
        wd_o        = inst_i.r.rd;     // Fixed rd position
        wreg_o      = 1'b0;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        reg1_addr_o = inst_i.r.rs1;
        reg2_addr_o = inst_i.r.rs2;

        case (inst_i.r.opcode)
            OPC_OP_IMM: begin
                wreg_o      = 1'b1;
                reg1_read_o = 1'b1;
                case (inst_i.i.funct3)
                    F3_ADD_SUB: {aluop_o, alusel_o} = {ALUOP_ADD, SEL_ARITH};
                    F3_SLT:     {aluop_o, alusel_o} = {ALUOP_SLT, SEL_ARITH};
                    F3_SLTU:    {aluop_o, alusel_o} = {ALUOP_SLTU, SEL_ARITH};
                    F3_XOR:     {aluop_o, alusel_o} = {ALUOP_XOR, SEL_LOGIC};
                    F3_OR:      {aluop_o, alusel_o} = {ALUOP_OR, SEL_LOGIC};
                    F3_AND:     {aluop_o, alusel_o} = {ALUOP_AND, SEL_LOGIC};
                    F3_SLL:     {aluop_o, alusel_o} = {ALUOP_SLL, SEL_SHIFT};
                    F3_SRL_SRA: begin
                        alusel_o = SEL_SHIFT;
                        aluop_o  = inst_i.i.imm12[10] ? ALUOP_SRA : ALUOP_SRL; // imm[10] marks SRAI
                    end
                    default: ;
                endcase
            end
            OPC_OP: begin
                if (f7_ok) begin
                    wreg_o      = 1'b1;
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                    case (inst_i.r.funct3)
                        F3_ADD_SUB: begin
                            alusel_o = SEL_ARITH;
                            aluop_o  = inst_i.r.funct7[5] ? ALUOP_SUB : ALUOP_ADD;
                        end
                        F3_SLT:     {aluop_o, alusel_o} = {ALUOP_SLT, SEL_ARITH};
                        F3_SLTU:    {aluop_o, alusel_o} = {ALUOP_SLTU, SEL_ARITH};
                        F3_XOR:     {aluop_o, alusel_o} = {ALUOP_XOR, SEL_LOGIC};
                        F3_OR:      {aluop_o, alusel_o} = {ALUOP_OR, SEL_LOGIC};
                        F3_AND:     {aluop_o, alusel_o} = {ALUOP_AND, SEL_LOGIC};
                        F3_SLL:     {aluop_o, alusel_o} = {ALUOP_SLL, SEL_SHIFT};
                        F3_SRL_SRA: begin
                            alusel_o = SEL_SHIFT;
                            aluop_o  = inst_i.r.funct7[5] ? ALUOP_SRA : ALUOP_SRL;
                        end
                        default: ;
                    endcase
                end
            end
            OPC_LUI: begin
                wreg_o               = 1'b1;
                {aluop_o, alusel_o}  = {ALUOP_LUI, SEL_LOGIC};
            end
            OPC_JAL: begin
                wreg_o               = 1'b1;
                {aluop_o, alusel_o}  = {ALUOP_JAL, SEL_JUMP_BRANCH};
            end
            OPC_JALR: begin
                wreg_o               = 1'b1;
                {aluop_o, alusel_o}  = {ALUOP_JALR, SEL_JUMP_BRANCH};
            end
            OPC_BRANCH: begin
                case (inst_i.r.funct3)
                    F3_BEQ:  aluop_o = ALUOP_BEQ;
                    F3_BNE:  aluop_o = ALUOP_BNE;
                    F3_BLT:  aluop_o = ALUOP_BLT;
                    F3_BGE:  aluop_o = ALUOP_BGE;
                    F3_BLTU: aluop_o = ALUOP_BLTU;
                    F3_BGEU: aluop_o = ALUOP_BGEU;
                    default: ;
                endcase
                if (aluop_o != ALUOP_NOP) begin // Funct3 010 and 011 stay a no-op
                    alusel_o    = SEL_JUMP_BRANCH;
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/1ns

module imm_gen (
    input  riscv_id_pkg::inst_u               inst_i,
    input  logic [riscv_id_pkg::XLEN-1:0]     pc_i,
    output logic [riscv_id_pkg::XLEN-1:0]     imm_o,
    output logic [riscv_id_pkg::XLEN-1:0]     link_addr_o,
    output logic [11:0]                       branch_offset_o
);
    import riscv_id_pkg::*;

    logic is_shift;

    assign is_shift = (inst_i.i.funct3 == F3_SLL) || (inst_i.i.funct3 == F3_SRL_SRA);

    always_comb begin
        imm_o       = '0;
        link_addr_o = '0;
        case (inst_i.i.opcode)
            OPC_OP_IMM: begin
                if (is_shift) begin
                    imm_o = {{(XLEN-5){1'b0}}, inst_i.i.imm12[4:0]}; // Shamt only
                end else begin
                    imm_o = {{(XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
                end
            end
            OPC_LUI:  imm_o = {inst_i.i.imm12, inst_i.i.rs1, inst_i.i.funct3, 12'h000};
            OPC_JAL:  link_addr_o = pc_i + XLEN'(4);
            OPC_JALR: link_addr_o = pc_i + XLEN'(4);
            default: ;
        endcase
    end

    // B-format bits 31, 7, 30:25, 11:8
    assign branch_offset_o = {inst_i.r.funct7[6], inst_i.r.rd[0],
                              inst_i.r.funct7[5:0], inst_i.r.rd[4:1]};

endmodule

// ==== operand_forward.sv ====
`timescale 1ns/1ns

module operand_forward (
    input  logic                                  read_i,
    input  logic [riscv_id_pkg::REG_ADDR_W-1:0]   addr_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         rf_data_i,
    input  logic                                  ex_wreg_i,
    input  logic [riscv_id_pkg::REG_ADDR_W-1:0]   ex_wd_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         ex_wdata_i,
    input  logic                                  mem_wreg_i,
    input  logic [riscv_id_pkg::REG_ADDR_W-1:0]   mem_wd_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         mem_wdata_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         imm_i,
    output logic [riscv_id_pkg::XLEN-1:0]         operand_o
);
    import riscv_id_pkg::*;

    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_wreg_i && (ex_wd_i == addr_i)) begin
            operand_o = ex_wdata_i;    // Youngest result wins
        end else if (mem_wreg_i && (mem_wd_i == addr_i)) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

// ==== id_ex_reg.sv ====
`timescale 1ns/1ns

module id_ex_reg (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic [riscv_id_pkg::ALUOP_W-1:0]      aluop_i,
    input  logic [riscv_id_pkg::ALUSEL_W-1:0]     alusel_i,
    input  logic [riscv_id_pkg::REG_ADDR_W-1:0]   wd_i,
    input  logic                                  wreg_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         reg1_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         reg2_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         link_addr_i,
    input  logic [11:0]                           branch_offset_i,
    output logic [riscv_id_pkg::ALUOP_W-1:0]      aluop_o,
    output logic [riscv_id_pkg::ALUSEL_W-1:0]     alusel_o,
    output logic [riscv_id_pkg::REG_ADDR_W-1:0]   wd_o,
    output logic                                  wreg_o,
    output logic [riscv_id_pkg::XLEN-1:0]         reg1_o,
    output logic [riscv_id_pkg::XLEN-1:0]         reg2_o,
    output logic [riscv_id_pkg::XLEN-1:0]         link_addr_o,
    output logic [11:0]                           branch_offset_o
);
    import riscv_id_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            aluop_o         <= ALUOP_NOP;  // Bubble into execute
            alusel_o        <= SEL_NOP;
            wd_o            <= '0;
            wreg_o          <= 1'b0;
            reg1_o          <= '0;
            reg2_o          <= '0;
            link_addr_o     <= '0;
            branch_offset_o <= '0;
        end else begin
            aluop_o         <= aluop_i;
            alusel_o        <= alusel_i;
            wd_o            <= wd_i;
            wreg_o          <= wreg_i;
            reg1_o          <= reg1_i;
            reg2_o          <= reg2_i;
            link_addr_o     <= link_addr_i;
            branch_offset_o <= branch_offset_i;
        end
    end

endmodule

// ==== riscv_id_top.sv ====
`timescale 1ns/1ns

module riscv_id_top (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         inst_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         pc_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         reg1_data_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         reg2_data_i,
    input  logic                                  ex_wreg_i,
    input  logic [riscv_id_pkg::REG_ADDR_W-1:0]   ex_wd_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         ex_wdata_i,
    input  logic                                  mem_wreg_i,
    input  logic [riscv_id_pkg::REG_ADDR_W-1:0]   mem_wd_i,
    input  logic [riscv_id_pkg::XLEN-1:0]         mem_wdata_i,
    output logic                                  reg1_read_o,
    output logic                                  reg2_read_o,
    output logic [riscv_id_pkg::REG_ADDR_W-1:0]   reg1_addr_o,
    output logic [riscv_id_pkg::REG_ADDR_W-1:0]   reg2_addr_o,
    output logic [riscv_id_pkg::ALUOP_W-1:0]      aluop_o,
    output logic [riscv_id_pkg::ALUSEL_W-1:0]     alusel_o,
    output logic [riscv_id_pkg::REG_ADDR_W-1:0]   wd_o,
    output logic                                  wreg_o,
    output logic [riscv_id_pkg::XLEN-1:0]         reg1_o,
    output logic [riscv_id_pkg::XLEN-1:0]         reg2_o,
    output logic [riscv_id_pkg::XLEN-1:0]         link_addr_o,
    output logic [11:0]                           branch_offset_o
);
    import riscv_id_pkg::*;

    logic [ALUOP_W-1:0]    dec_aluop;
    logic [ALUSEL_W-1:0]   dec_alusel;
    logic [REG_ADDR_W-1:0] dec_wd;
    logic                  dec_wreg;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       link_addr;
    logic [11:0]           branch_offset;
    logic [XLEN-1:0]       reg1_fwd;
    logic [XLEN-1:0]       reg2_fwd;

    inst_decoder u_decoder (
        .inst_i(inst_i), .aluop_o(dec_aluop), .alusel_o(dec_alusel),
        .wd_o(dec_wd), .wreg_o(dec_wreg),
        .reg1_read_o(reg1_read_o), .reg2_read_o(reg2_read_o),
        .reg1_addr_o(reg1_addr_o), .reg2_addr_o(reg2_addr_o)
    );

    imm_gen u_imm_gen (
        .inst_i(inst_i), .pc_i(pc_i), .imm_o(imm),
        .link_addr_o(link_addr), .branch_offset_o(branch_offset)
    );

    operand_forward u_fwd_rs1 (
        .read_i(reg1_read_o), .addr_i(reg1_addr_o), .rf_data_i(reg1_data_i),
        .ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i), .ex_wdata_i(ex_wdata_i),
        .mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i), .mem_wdata_i(mem_wdata_i),
        .imm_i(imm), .operand_o(reg1_fwd)
    );

    operand_forward u_fwd_rs2 (
        .read_i(reg2_read_o), .addr_i(reg2_addr_o), .rf_data_i(reg2_data_i),
        .ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i), .ex_wdata_i(ex_wdata_i),
        .mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i), .mem_wdata_i(mem_wdata_i),
        .imm_i(imm), .operand_o(reg2_fwd)
    );

    id_ex_reg u_id_ex (
        .clk(clk), .rst_n_i(rst_n_i),
        .aluop_i(dec_aluop), .alusel_i(dec_alusel), .wd_i(dec_wd), .wreg_i(dec_wreg),
        .reg1_i(reg1_fwd), .reg2_i(reg2_fwd),
        .link_addr_i(link_addr), .branch_offset_i(branch_offset),
        .aluop_o(aluop_o), .alusel_o(alusel_o), .wd_o(wd_o), .wreg_o(wreg_o),
        .reg1_o(reg1_o), .reg2_o(reg2_o),
        .link_addr_o(link_addr_o), .branch_offset_o(branch_offset_o)
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;  // 10 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== tb_riscv_id.sv ====
`timescale 1ns/1ns

module tb_riscv_id;

    localparam int MAX_VEC = 64;
    localparam int N_COL   = 22;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst, pc, reg1_data, reg2_data;
    logic        ex_wreg, mem_wreg;
    logic [4:0]  ex_wd, mem_wd;
    logic [31:0] ex_wdata, mem_wdata;
    logic        reg1_read, reg2_read;
    logic [4:0]  reg1_addr, reg2_addr;
    logic [7:0]  aluop;
    logic [2:0]  alusel;
    logic [4:0]  wd;
    logic        wreg;
    logic [31:0] reg1, reg2, link_addr;
    logic [11:0] branch_offset;

    // Columns 0..9 are inputs, 10..21 expected values
    logic [31:0] vec [0:MAX_VEC-1][0:N_COL-1];
    int          n_vec;
    int          timeout_cycles = 20;
    int          cycle_cnt = 0;

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    riscv_id_top UUT (
        .clk(clk), .rst_n_i(rst_n),
        .inst_i(inst), .pc_i(pc),
        .reg1_data_i(reg1_data), .reg2_data_i(reg2_data),
        .ex_wreg_i(ex_wreg), .ex_wd_i(ex_wd), .ex_wdata_i(ex_wdata),
        .mem_wreg_i(mem_wreg), .mem_wd_i(mem_wd), .mem_wdata_i(mem_wdata),
        .reg1_read_o(reg1_read), .reg2_read_o(reg2_read),
        .reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr),
        .aluop_o(aluop), .alusel_o(alusel), .wd_o(wd), .wreg_o(wreg),
        .reg1_o(reg1), .reg2_o(reg2),
        .link_addr_o(link_addr), .branch_offset_o(branch_offset)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("TEST FAILED");
            $fatal(1, "Timeout: the run did not finish within %0d cycles", timeout_cycles);
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    rc;
        string line;
        fd = $fopen("id_input.txt", "r");
        if (fd == 0) begin
            $display("TEST FAILED");
            $fatal(1, "Could not open the vector file id_input.txt");
        end
        n_vec = 0;
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc == 0) break;
            if (line.len() < 8 || line.getc(0) == "#") continue;  // Comments and blanks
            if (n_vec >= MAX_VEC) begin
                $display("TEST FAILED");
                $fatal(1, "Too many vector lines in id_input.txt");
            end
            rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         vec[n_vec][0], vec[n_vec][1], vec[n_vec][2], vec[n_vec][3],
                         vec[n_vec][4], vec[n_vec][5], vec[n_vec][6], vec[n_vec][7],
                         vec[n_vec][8], vec[n_vec][9], vec[n_vec][10], vec[n_vec][11],
                         vec[n_vec][12], vec[n_vec][13], vec[n_vec][14], vec[n_vec][15],
                         vec[n_vec][16], vec[n_vec][17], vec[n_vec][18], vec[n_vec][19],
                         vec[n_vec][20], vec[n_vec][21]);
            if (rc != N_COL) begin
                $display("TEST FAILED");
                $fatal(1, "Malformed line in id_input.txt: %s", line);
            end
            n_vec++;
        end
        $fclose(fd);
    endtask

    task automatic drive_inputs(input int k);
        inst      = vec[k][0];
        pc        = vec[k][1];
        reg1_data = vec[k][2];
        reg2_data = vec[k][3];
        ex_wreg   = vec[k][4][0];
        ex_wd     = vec[k][5][4:0];
        ex_wdata  = vec[k][6];
        mem_wreg  = vec[k][7][0];
        mem_wd    = vec[k][8][4:0];
        mem_wdata = vec[k][9];
    endtask

    // Read requests follow the instruction within the same cycle
    task automatic check_comb(input int k);
        check_value(32'(reg1_read), vec[k][10], "reg1_read");
        check_value(32'(reg2_read), vec[k][11], "reg2_read");
        check_value(32'(reg1_addr), vec[k][12], "reg1_addr");
        check_value(32'(reg2_addr), vec[k][13], "reg2_addr");
    endtask

    task automatic check_regs(input int k);
        check_value(32'(aluop), vec[k][14], "aluop");
        check_value(32'(alusel), vec[k][15], "alusel");
        check_value(32'(wd), vec[k][16], "wd");
        check_value(32'(wreg), vec[k][17], "wreg");
        check_value(reg1, vec[k][18], "reg1");
        check_value(reg2, vec[k][19], "reg2");
        check_value(link_addr, vec[k][20], "link_addr");
        check_value(32'(branch_offset), vec[k][21], "branch_offset");
    endtask

    task automatic check_reset();
        check_value(32'(aluop), 32'h00, "aluop after reset");
        check_value(32'(alusel), 32'h0, "alusel after reset");
        check_value(32'(wd), 32'h0, "wd after reset");
        check_value(32'(wreg), 32'h0, "wreg after reset");
        check_value(reg1, 32'h0, "reg1 after reset");
        check_value(reg2, 32'h0, "reg2 after reset");
        check_value(link_addr, 32'h0, "link_addr after reset");
        check_value(32'(branch_offset), 32'h0, "branch_offset after reset");
    endtask

    initial begin
        inst      = '0;
        pc        = '0;
        reg1_data = '0;
        reg2_data = '0;
        ex_wreg   = 1'b0;
        ex_wd     = '0;
        ex_wdata  = '0;
        mem_wreg  = 1'b0;
        mem_wd    = '0;
        mem_wdata = '0;
        load_vectors();
        timeout_cycles = n_vec + 20;
        @(negedge clk);
        drive_inputs(0);          // Nonzero decode while reset is held
        @(posedge rst_n);
        check_reset();
        for (int k = 0; k < n_vec; k++) begin
            @(negedge clk);
            drive_inputs(k);
            #4;                   // Just before the rising edge
            check_comb(k);
            if (k > 0) begin
                check_regs(k - 1);    // Register still holds the previous line
            end
            @(posedge clk);
        end
        #1;
        check_regs(n_vec - 1);
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== id_input.txt ====
# inst pc rf1 rf2 exw exwd exdat memw memwd memdat | rd1 rd2 a1 a2 aluop sel wd wreg
# op1 op2 link boff (all hex)
FFD30293 100 1111 2222 0 0 0 0 0 0 1 0 06 1d 20 4 05 1 1111 FFFFFFFD 0 ff2
06432293 100 1111 2222 0 0 0 0 0 0 1 0 06 04 2a 4 05 1 1111 64 0 432
7FF33293 100 1111 2222 0 0 0 0 0 0 1 0 06 1f 2b 4 05 1 1111 7ff 0 7f2
0F034293 100 1111 2222 0 0 0 0 0 0 1 0 06 10 26 1 05 1 1111 f0 0 472
80036293 100 1111 2222 0 0 0 0 0 0 1 0 06 00 25 1 05 1 1111 FFFFF800 0 c02
00F37293 100 1111 2222 0 0 0 0 0 0 1 0 06 0f 24 1 05 1 1111 f 0 402
00331293 100 1111 2222 0 0 0 0 0 0 1 0 06 03 7c 2 05 1 1111 3 0 402
01F35293 100 1111 2222 0 0 0 0 0 0 1 0 06 1f 02 2 05 1 1111 1f 0 402
40735293 100 1111 2222 0 0 0 0 0 0 1 0 06 07 03 2 05 1 1111 7 0 602
007302B3 100 1111 2222 0 0 0 0 0 0 1 1 06 07 20 4 05 1 1111 2222 0 402
407302B3 100 1111 2222 0 0 0 0 0 0 1 1 06 07 22 4 05 1 1111 2222 0 602
007312B3 100 1111 2222 0 0 0 0 0 0 1 1 06 07 7c 2 05 1 1111 2222 0 402
007322B3 100 1111 2222 0 0 0 0 0 0 1 1 06 07 2a 4 05 1 1111 2222 0 402
007332B3 100 1111 2222 0 0 0 0 0 0 1 1 06 07 2b 4 05 1 1111 2222 0 402
007342B3 100 1111 2222 0 0 0 0 0 0 1 1 06 07 26 1 05 1 1111 2222 0 402
007352B3 100 1111 2222 0 0 0 0 0 0 1 1 06 07 02 2 05 1 1111 2222 0 402
407352B3 100 1111 2222 0 0 0 0 0 0 1 1 06 07 03 2 05 1 1111 2222 0 602
007362B3 100 1111 2222 0 0 0 0 0 0 1 1 06 07 25 1 05 1 1111 2222 0 402
007372B3 100 1111 2222 0 0 0 0 0 0 1 1 06 07 24 1 05 1 1111 2222 0 402
007302B3 100 1111 2222 1 6 aaaa 1 6 bbbb 1 1 06 07 20 4 05 1 aaaa 2222 0 402
007302B3 100 1111 2222 1 9 aaaa 1 6 bbbb 1 1 06 07 20 4 05 1 bbbb 2222 0 402
007302B3 100 1111 2222 0 6 aaaa 1 7 bbbb 1 1 06 07 20 4 05 1 1111 bbbb 0 402
007302B3 100 1111 2222 1 7 aaaa 1 7 bbbb 1 1 06 07 20 4 05 1 1111 aaaa 0 402
123452B7 100 1111 2222 0 0 0 0 0 0 0 0 08 03 5c 1 05 1 12345000 12345000 0 492
010000EF 100 1111 2222 0 0 0 0 0 0 0 0 00 10 50 6 01 1 0 0 104 400
008302E7 200 1111 2222 0 0 0 0 0 0 0 0 06 08 09 6 05 1 0 0 204 402
00730463 100 1111 2222 0 0 0 0 0 0 1 1 06 07 51 6 08 0 1111 2222 0 004
FE731EE3 100 1111 2222 0 0 0 0 0 0 1 1 06 07 52 6 1d 0 1111 2222 0 ffe
02734063 100 1111 2222 0 0 0 0 0 0 1 1 06 07 53 6 00 0 1111 2222 0 010
807350E3 100 1111 2222 0 0 0 0 0 0 1 1 06 07 54 6 01 0 1111 2222 0 c00
54736B63 100 1111 2222 0 0 0 0 0 0 1 1 06 07 55 6 16 0 1111 2222 0 2ab
00737163 100 1111 2222 1 7 aaaa 0 0 0 1 1 06 07 56 6 02 0 1111 aaaa 0 001
00000000 100 1111 2222 0 0 0 0 0 0 0 0 00 00 00 0 00 0 0 0 0 000

// ==== riscv_id_top.f ====
riscv_id_pkg.sv
inst_decoder.sv
imm_gen.sv
operand_forward.sv
id_ex_reg.sv
riscv_id_top.sv
tb_clk_gen.sv
tb_riscv_id.sv

// ==== Makefile ====
TOP = tb_riscv_id

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f riscv_id_top.f

sim:
	verilator --binary --top-module $(TOP) -f riscv_id_top.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
